// ==== lsu_top.f ====
rtl/lsu_pkg.sv
rtl/lsu_req_gen.sv
rtl/lsu_txn_ctrl.sv
rtl/lsu_rdata_align.sv
rtl/lsu_top.sv
tests/tb_clk_gen.sv
tests/lsu_bus_model.sv
tests/lsu_tb.sv

// ==== rtl/lsu_pkg.sv ====
// Shared definitions for the load/store unit
// Data widths, access-size encoding, byte offset and counter types
// Outstanding transaction limit

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  parameter int XLEN = 32;                // Data and address width
  parameter int BE_W = XLEN / 8;          // Byte lanes per bus word

  // Outstanding bus transactions, tied to one set of WB registers
  parameter int LSU_DEPTH = 2;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // Access size, same coding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    LSU_SIZE_B = 2'd0,                    // Byte
    LSU_SIZE_H = 2'd1,                    // Halfword
    LSU_SIZE_W = 2'd2                     // Word
  } lsu_size_e;

  // Byte offset inside a word
  typedef logic [1:0] byte_off_t;

  // Outstanding transaction count, 0 to LSU_DEPTH
  typedef logic [1:0] txn_cnt_t;

endpackage

// ==== rtl/lsu_rdata_align.sv ====
// WB stage read data
// Control registers, misaligned load assembly, sign and zero extension

`timescale 1ns/100ps

module lsu_rdata_align (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ctrl_update_i,     // EX access accepted
  input  lsu_pkg::lsu_size_e         size_i,
  input  logic                       sign_ext_i,
  input  logic                       we_i,
  input  lsu_pkg::byte_off_t         offset_i,
  input  logic                       misaligned_i,      // Second phase now in EX
  input  logic                       misaligned_0_i,    // First phase now in EX
  input  logic                       rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0]   rdata_i,
  output logic [lsu_pkg::XLEN-1:0]   rdata_1_o
);

  import lsu_pkg::*;

  // WB copy of the access
  lsu_size_e       size_q;
  logic            sign_ext_q;
  logic            we_q;
  byte_off_t       offset_q;

  logic [XLEN-1:0] rdata_q;               // First phase raw data or last result
  logic [15:0]     half_sel;
  logic [7:0]      byte_sel;
  logic [XLEN-1:0] rdata_w;
  logic [XLEN-1:0] rdata_h;
  logic [XLEN-1:0] rdata_b;
  logic [XLEN-1:0] rdata_ext;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      size_q     <= LSU_SIZE_B;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
      offset_q   <= '0;
    end
    else if (ctrl_update_i)
    begin
      size_q     <= size_i;
      sign_ext_q <= sign_ext_i;
      we_q       <= we_i;
      offset_q   <= offset_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Lane selection and extension
  ////////////////////////////////////////////////////////////

  // Word. Split loads join new low bytes with the held upper bytes
  always_comb
  begin
    case (offset_q)
      2'b00:   rdata_w = rdata_i;
      2'b01:   rdata_w = {rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   rdata_w = {rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // Halfword, offset 3 spans two responses
  always_comb
  begin
    case (offset_q)
      2'b00:   half_sel = rdata_i[15:0];
      2'b01:   half_sel = rdata_i[23:8];
      2'b10:   half_sel = rdata_i[31:16];
      default: half_sel = {rdata_i[7:0], rdata_q[31:24]};
    endcase
  end

  assign byte_sel = rdata_i[8*offset_q +: 8];     // One lane

  assign rdata_h = {{16{sign_ext_q & half_sel[15]}}, half_sel};
  assign rdata_b = {{24{sign_ext_q & byte_sel[7]}}, byte_sel};

  always_comb
  begin
    case (size_q)
      LSU_SIZE_B: rdata_ext = rdata_b;
      LSU_SIZE_H: rdata_ext = rdata_h;
      default:    rdata_ext = rdata_w;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Held data
  ////////////////////////////////////////////////////////////

  // While a split is under way the raw word is kept for the second phase
  always_ff @(posedge clk)
  begin
    if (rvalid_i && !we_q)
    begin
      if (misaligned_i || misaligned_0_i)
        rdata_q <= rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  assign rdata_1_o = rvalid_i ? rdata_ext : rdata_q;

endmodule

// ==== rtl/lsu_req_gen.sv ====
// EX stage request builder
// Address adder, misaligned detection, byte enables, store data rotation

`timescale 1ns/100ps

module lsu_req_gen (
  input  logic                       lsu_en_i,
  input  lsu_pkg::lsu_size_e         size_i,
  input  logic                       we_i,
  input  logic                       misaligned_i,      // Second phase in EX
  input  logic [lsu_pkg::XLEN-1:0]   operand_a_i,
  input  logic [lsu_pkg::XLEN-1:0]   operand_b_i,
  input  logic [lsu_pkg::XLEN-1:0]   wdata_i,
  output logic [lsu_pkg::XLEN-1:0]   addr_o,
  output lsu_pkg::byte_off_t         offset_o,
  output logic [lsu_pkg::BE_W-1:0]   be_o,
  output logic [lsu_pkg::XLEN-1:0]   wdata_o,
  output logic                       misaligned_0_o
);

  import lsu_pkg::*;

  logic [XLEN-1:0] addr_raw;              // Operand sum
  byte_off_t       offset;
  logic [XLEN-1:0] wdata_rot;

  assign addr_raw = operand_a_i + operand_b_i;
  assign offset   = addr_raw[1:0];
  assign offset_o = offset;

  // Second phase always starts at lane 0 of the next word
  assign addr_o = misaligned_i ? {addr_raw[XLEN-1:2], 2'b00} : addr_raw;

  ////////////////////////////////////////////////////////////
  // Misaligned detection
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    misaligned_0_o = 1'b0;
    if (lsu_en_i && !misaligned_i)        // Never split the second phase again
    begin
      case (size_i)
        LSU_SIZE_W: misaligned_0_o = (offset != 2'b00);
        LSU_SIZE_H: misaligned_0_o = (offset == 2'b11);  // Crosses into next word
        default:    misaligned_0_o = 1'b0;               // Bytes always fit
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (size_i)
      LSU_SIZE_B:
      begin
        be_o = 4'b0001 << offset;         // One lane at the offset
      end
      LSU_SIZE_H:
      begin
        if (misaligned_i)
          be_o = 4'b0001;                 // Upper byte lands in lane 0
        else
        begin
          case (offset)
            2'b00:   be_o = 4'b0011;
            2'b01:   be_o = 4'b0110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;      // First phase of a split
          endcase
        end
      end
      default:
      begin
        // Word takes the lanes from the offset up in the first phase
        // and the lanes below the offset in the second
        if (misaligned_i)
          be_o = ~(4'b1111 << offset);
        else
          be_o = 4'b1111 << offset;
      end
    endcase
  end

  // Store data moves left by the offset, so byte 0 sits in its lane
  always_comb
  begin
    case (offset)
      2'b00:   wdata_rot = wdata_i;
      2'b01:   wdata_rot = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_rot = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_rot = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  assign wdata_o = we_i ? wdata_rot : '0;  // Quiet write bus on loads

endmodule

// ==== rtl/lsu_top.sv ====
// Load/store unit top level
// EX request builder, transaction control and WB read-data aligner

`timescale 1ns/100ps

module lsu_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // EX stage from the pipeline
  input  logic                       lsu_en_i,            // Held until ready_0_o
  input  lsu_pkg::lsu_size_e         size_i,
  input  logic                       sign_ext_i,
  input  logic                       we_i,
  input  logic                       misaligned_i,        // Second phase of a split access
  input  logic [lsu_pkg::XLEN-1:0]   operand_a_i,
  input  logic [lsu_pkg::XLEN-1:0]   operand_b_i,
  input  logic [lsu_pkg::XLEN-1:0]   wdata_i,
  output logic                       ready_0_o,
  output logic                       lsu_misaligned_0_o,
  output logic                       busy_o,

  // Data bus
  output logic                       data_req_o,
  input  logic                       data_gnt_i,
  output logic [lsu_pkg::XLEN-1:0]   data_addr_o,
  output logic                       data_we_o,
  output logic [lsu_pkg::BE_W-1:0]   data_be_o,
  output logic [lsu_pkg::XLEN-1:0]   data_wdata_o,
  input  logic                       data_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0]   data_rdata_i,
  input  logic                       data_err_i,

  // WB stage
  output logic                       valid_1_o,
  output logic [lsu_pkg::XLEN-1:0]   lsu_rdata_1_o,
  output logic                       lsu_err_1_o,
  output logic [lsu_pkg::XLEN-1:0]   lsu_addr_1_o
);

  import lsu_pkg::*;

  byte_off_t addr_offset;                 // Raw byte offset of the EX address
  logic      ctrl_update;                 // EX access moves into WB

  assign data_we_o = we_i;                // Direction goes straight onto the bus

  ////////////////////////////////////////////////////////////
  // EX stage request builder
  ////////////////////////////////////////////////////////////

  lsu_req_gen u_req_gen (
    .lsu_en_i       (lsu_en_i),
    .size_i         (size_i),
    .we_i           (we_i),
    .misaligned_i   (misaligned_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .wdata_i        (wdata_i),
    .addr_o         (data_addr_o),
    .offset_o       (addr_offset),
    .be_o           (data_be_o),
    .wdata_o        (data_wdata_o),
    .misaligned_0_o (lsu_misaligned_0_o)
  );

  // Handshakes, outstanding count and error address
  lsu_txn_ctrl u_txn_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .lsu_en_i       (lsu_en_i),
    .misaligned_0_i (lsu_misaligned_0_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .addr_i         (data_addr_o),
    .req_o          (data_req_o),
    .ready_0_o      (ready_0_o),
    .ctrl_update_o  (ctrl_update),
    .valid_1_o      (valid_1_o),
    .err_1_o        (lsu_err_1_o),
    .busy_o         (busy_o),
    .addr_1_o       (lsu_addr_1_o)
  );

  ////////////////////////////////////////////////////////////
  // WB stage load data
  ////////////////////////////////////////////////////////////

  lsu_rdata_align u_rdata_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_update_i  (ctrl_update),
    .size_i         (size_i),
    .sign_ext_i     (sign_ext_i),
    .we_i           (we_i),
    .offset_i       (addr_offset),
    .misaligned_i   (misaligned_i),
    .misaligned_0_i (lsu_misaligned_0_o),
    .rvalid_i       (data_rvalid_i),
    .rdata_i        (data_rdata_i),
    .rdata_1_o      (lsu_rdata_1_o)
  );

endmodule

// ==== rtl/lsu_txn_ctrl.sv ====
// Transaction control
// Outstanding counter, EX ready, WB valid, busy and error address

`timescale 1ns/100ps

module lsu_txn_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       lsu_en_i,
  input  logic                       misaligned_0_i,    // First phase of a split access
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic                       data_err_i,
  input  logic [lsu_pkg::XLEN-1:0]   addr_i,            // Bus address of the request
  output logic                       req_o,
  output logic                       ready_0_o,
  output logic                       ctrl_update_o,
  output logic                       valid_1_o,
  output logic                       err_1_o,
  output logic                       busy_o,
  output logic [lsu_pkg::XLEN-1:0]   addr_1_o
);

  import lsu_pkg::*;

  txn_cnt_t cnt_q;                        // Granted, not yet answered
  txn_cnt_t cnt_d;
  logic     granted;
  logic     last_q;                       // WB access is the last phase

  ////////////////////////////////////////////////////////////
  // Request and handshakes
  ////////////////////////////////////////////////////////////

  // No combinational path from rvalid to req
  assign req_o   = lsu_en_i && (cnt_q < LSU_DEPTH);
  assign granted = req_o && data_gnt_i;

  // EX and WB advance together once WB is occupied
  always_comb
  begin
    if (!lsu_en_i)
      ready_0_o = 1'b1;                   // Nothing to issue
    else if (cnt_q == 2'd0)
      ready_0_o = granted;
    else if (cnt_q == 2'd1)
      ready_0_o = granted && data_rvalid_i;
    else
      ready_0_o = data_rvalid_i;          // Request already granted, WB frees up
  end

  assign ctrl_update_o = ready_0_o && lsu_en_i;

  // Only the final phase of a split access reaches WB
  assign valid_1_o = (cnt_q != 2'd0) && last_q && data_rvalid_i;
  assign err_1_o   = data_rvalid_i && data_err_i;  // Either phase

  assign busy_o = (cnt_q != 2'd0) || req_o;

  ////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case ({granted, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + 2'd1;
      2'b01:   cnt_d = cnt_q - 2'd1;
      default: cnt_d = cnt_q;             // Idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q  <= '0;
      last_q <= 1'b0;
    end
    else
    begin
      cnt_q <= cnt_d;
      if (ctrl_update_o)
        last_q <= !misaligned_0_i;        // First phase of split is not last
    end
  end

  // Address of the last granted request, for bus error reporting
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      addr_1_o <= '0;
    else if (granted)
      addr_1_o <= addr_i;
  end

endmodule

// ==== tests/lsu_bus_model.sv ====
// Data memory on the request/grant/rvalid bus
// Random grant and response delays, error on addresses with bit 31 set

`timescale 1ns/100ps

module lsu_bus_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        data_req_i,
  output logic        data_gnt_o,
  input  logic [31:0] data_addr_i,
  input  logic        data_we_i,
  input  logic [3:0]  data_be_i,
  input  logic [31:0] data_wdata_i,
  output logic        data_rvalid_o,
  output logic [31:0] data_rdata_o,
  output logic        data_err_o
);

  logic [31:0] mem [int unsigned];        // Only words written so far
  logic [31:0] rsp_data_q [$];            // Pending responses, in order
  logic        rsp_err_q [$];
  int unsigned rsp_due_q [$];             // Cycle from which a response may go out
  int unsigned cyc;
  int unsigned gnt_wait;                  // Request cycles left before grant

  // Unwritten word n holds byte n+k in lane k
  function automatic logic [31:0] read_word(input logic [29:0] n);
    logic [31:0] word;
    word = n * 32'h01010101 + 32'h03020100;
    if (mem.exists(n))
      word = mem[n];
    return word;
  endfunction

  // Store takes effect at grant, so later loads see it
  task automatic accept_request();
    logic [31:0] word;
    word = read_word(data_addr_i[31:2]);
    if (!data_addr_i[31] && data_we_i)
    begin
      for (int i = 0; i < 4; i++)
        if (data_be_i[i])
          word[8*i +: 8] = data_wdata_i[8*i +: 8];   // Enabled lanes only
      mem[data_addr_i[31:2]] = word;
    end
    rsp_data_q.push_back(data_addr_i[31] ? 32'h0 : word);
    rsp_err_q.push_back(data_addr_i[31]);
    rsp_due_q.push_back(cyc + ($urandom % 4));
  endtask

  initial
  begin
    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    data_rdata_o  = '0;
    data_err_o    = 1'b0;
    cyc           = 0;
    gnt_wait      = 0;
  end

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_gnt_o    <= 1'b0;
      data_rvalid_o <= 1'b0;
      data_err_o    <= 1'b0;
      gnt_wait = $urandom % 4;
    end
    else
    begin
      cyc++;
      if (data_req_i && data_gnt_o)
      begin
        accept_request();
        gnt_wait = $urandom % 4;          // Next grant may already be up
      end
      else if (data_req_i && gnt_wait != 0)
        gnt_wait--;
      data_gnt_o <= (gnt_wait == 0);

      // One response per cycle, at least one cycle after its grant
      if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc)
      begin
        data_rvalid_o <= 1'b1;
        data_rdata_o  <= rsp_data_q.pop_front();
        data_err_o    <= rsp_err_q.pop_front();
        void'(rsp_due_q.pop_front());
      end
      else
      begin
        data_rvalid_o <= 1'b0;
        data_err_o    <= 1'b0;
      end
    end
  end

endmodule

// ==== tests/lsu_golden.txt ====
// size(0 b,1 h,2 w) we sign operand_a operand_b wdata exp_rdata exp_err
// exp_rdata is checked for loads without error; word n starts as bytes n,n+1,n+2,n+3
0 0 1 00000200 00000001 00000000 ffffff81 0  // lb 0x201
0 0 0 00000200 00000003 00000000 00000083 0  // lbu 0x203
0 0 1 000000f0 00000010 00000000 00000040 0  // lb 0x100
0 0 1 00000201 00000001 00000000 ffffff82 0  // lb 0x202
1 0 1 00000200 00000002 00000000 ffff8382 0  // lh 0x202
1 0 0 00000100 00000101 00000000 00008281 0  // lhu 0x201
1 0 1 00000100 00000000 00000000 00004140 0  // lh 0x100
2 0 0 00000200 00000004 00000000 84838281 0  // lw 0x204
2 0 0 00000200 00000001 00000000 81838281 0  // lw 0x201 split
2 0 0 00000080 00000082 00000000 42414342 0  // lw 0x102 split
2 0 0 00000203 00000000 00000000 83828183 0  // lw 0x203 split
1 0 1 00000200 00000003 00000000 ffff8183 0  // lh 0x203 split
1 0 0 00000100 00000003 00000000 00004143 0  // lhu 0x103 split
0 1 0 00000300 00000001 000000aa 00000000 0  // sb 0x301
1 1 0 00000300 00000002 00005566 00000000 0  // sh 0x302
2 0 0 00000300 00000000 00000000 5566aac0 0  // lw 0x300
2 1 0 00000300 00000003 11223344 00000000 0  // sw 0x303 split
2 0 0 00000300 00000000 00000000 4466aac0 0  // lw 0x300
2 0 0 00000300 00000004 00000000 c4112233 0  // lw 0x304
1 1 0 00000300 00000007 0000beef 00000000 0  // sh 0x307 split
1 0 1 00000300 00000007 00000000 ffffbeef 0  // lh 0x307 split
2 0 0 00000300 00000008 00000000 c5c4c3be 0  // lw 0x308
2 1 0 00000300 0000000c cafef00d 00000000 0  // sw 0x30c
2 0 0 00000300 0000000c 00000000 cafef00d 0  // lw 0x30c
2 0 0 80000000 00000010 00000000 00000000 1  // lw error
2 1 0 80000000 00000020 12345678 00000000 1  // sw error
2 0 0 00000100 00000004 00000000 44434241 0  // lw 0x104

// ==== tests/lsu_tb.sv ====
// Testbench top for the load/store unit
// Golden file playback, response and error checks, outstanding count
// and a watchdog

`timescale 1ns/100ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int MAX_LINES = 64;
  localparam int FIELDS    = 8;           // Words per golden line
  localparam int F_SIZE    = 0;
  localparam int F_WE      = 1;
  localparam int F_SIGN    = 2;
  localparam int F_OPA     = 3;
  localparam int F_OPB     = 4;
  localparam int F_WDATA   = 5;
  localparam int F_RDATA   = 6;
  localparam int F_ERR     = 7;

  logic            clk;
  logic            rst_n;
  logic            lsu_en;
  lsu_size_e       size;
  logic            sign_ext;
  logic            we;
  logic            misaligned;
  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;
  logic [XLEN-1:0] wdata;
  logic            ready_0;
  logic            lsu_misaligned_0;
  logic            busy;
  logic            data_req;
  logic            data_gnt;
  logic [XLEN-1:0] data_addr;
  logic            data_we;
  logic [3:0]      data_be;
  logic [XLEN-1:0] data_wdata;
  logic            data_rvalid;
  logic [XLEN-1:0] data_rdata;
  logic            data_err;
  logic            valid_1;
  logic [XLEN-1:0] lsu_rdata_1;
  logic            lsu_err_1;
  logic [XLEN-1:0] lsu_addr_1;

  logic [XLEN-1:0] gold [0:FIELDS*MAX_LINES-1];
  int              pend_q [$];            // Accesses waiting for valid_1_o
  int              n_lines   = 0;
  int              exp_gnts  = 0;         // Bus transactions the accesses need
  int              gnt_total = 0;
  int              outst     = 0;         // Granted minus answered

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  lsu_bus_model u_bus (
    .clk(clk), .rst_n(rst_n),
    .data_req_i(data_req), .data_gnt_o(data_gnt), .data_addr_i(data_addr),
    .data_we_i(data_we), .data_be_i(data_be), .data_wdata_i(data_wdata),
    .data_rvalid_o(data_rvalid), .data_rdata_o(data_rdata), .data_err_o(data_err)
  );

  lsu_top DUT (
    .clk(clk), .rst_n(rst_n),
    .lsu_en_i(lsu_en), .size_i(size), .sign_ext_i(sign_ext), .we_i(we),
    .misaligned_i(misaligned), .operand_a_i(opa), .operand_b_i(opb), .wdata_i(wdata),
    .ready_0_o(ready_0), .lsu_misaligned_0_o(lsu_misaligned_0), .busy_o(busy),
    .data_req_o(data_req), .data_gnt_i(data_gnt), .data_addr_o(data_addr),
    .data_we_o(data_we), .data_be_o(data_be), .data_wdata_o(data_wdata),
    .data_rvalid_i(data_rvalid), .data_rdata_i(data_rdata), .data_err_i(data_err),
    .valid_1_o(valid_1), .lsu_rdata_1_o(lsu_rdata_1), .lsu_err_1_o(lsu_err_1),
    .lsu_addr_1_o(lsu_addr_1)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] field(input int line, input int f);
    return gold[FIELDS*line + f];
  endfunction

  function automatic logic [XLEN-1:0] access_addr(input int line);
    return field(line, F_OPA) + field(line, F_OPB);
  endfunction

  // Word off a word boundary, or halfword crossing into the next word
  function automatic logic splits_access(input logic [XLEN-1:0] sz, input logic [XLEN-1:0] a);
    return (sz == 2 && a[1:0] != 2'b00) || (sz == 1 && a[1:0] == 2'b11);
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "first error, run stopped");
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    if (exp !== act)
      stop_run($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
  endtask

  task automatic expect_idle(input string when);
    check_value({when, " valid_1_o"}, 0, valid_1);
    check_value({when, " lsu_err_1_o"}, 0, lsu_err_1);
    check_value({when, " busy_o"}, 0, busy);
    check_value({when, " lsu_addr_1_o"}, 0, lsu_addr_1);
  endtask

  // Entered and left on a rising edge
  task automatic wait_accept(output logic mis);
    do
      @(negedge clk);
    while (ready_0 !== 1'b1);
    mis = lsu_misaligned_0;               // Flag at acceptance
    @(posedge clk);
  endtask

  task automatic wait_drain();
    while (pend_q.size() != 0)
      @(posedge clk);
  endtask

  task automatic run_access(input int idx);
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] sz;
    logic            split;
    logic            mis;
    addr  = access_addr(idx);
    sz    = field(idx, F_SIZE);
    split = splits_access(sz, addr);
    pend_q.push_back(idx);
    exp_gnts += split ? 2 : 1;
    lsu_en     <= 1'b1;
    size       <= lsu_size_e'(sz[1:0]);
    sign_ext   <= field(idx, F_SIGN) != 0;
    we         <= field(idx, F_WE) != 0;
    misaligned <= 1'b0;
    opa        <= field(idx, F_OPA);
    opb        <= field(idx, F_OPB);
    wdata      <= field(idx, F_WDATA);
    wait_accept(mis);
    check_value($sformatf("access %0d misaligned flag", idx), split, mis);
    if (split)
    begin
      misaligned <= 1'b1;                 // Next word, same byte offset
      opb        <= field(idx, F_OPB) + 32'd4;
      wait_accept(mis);
      check_value($sformatf("access %0d second phase flag", idx), 0, mis);
      misaligned <= 1'b0;
    end
    if (field(idx, F_ERR) != 0)
    begin
      lsu_en <= 1'b0;                     // Error address must stay the last granted
      wait_drain();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Response monitor
  ////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (rst_n === 1'b1)
    begin
      if (data_req && data_gnt)
      begin
        gnt_total++;
        outst++;
      end
      if (data_rvalid)
        outst--;
      check_value("outstanding limit", 1, outst <= 2);
      if (lsu_err_1)
      begin
        if (pend_q.size() == 0)
          stop_run("bus error reported with no access pending");
        else
          check_value($sformatf("access %0d error address", pend_q[0]),
                      access_addr(pend_q[0]), lsu_addr_1);
      end
      if (valid_1)
      begin
        if (pend_q.size() == 0)
          stop_run("valid_1_o raised with no access pending");
        else
        begin
          int idx;
          idx = pend_q.pop_front();
          check_value($sformatf("access %0d error flag", idx), field(idx, F_ERR), lsu_err_1);
          if (field(idx, F_WE) == 0 && field(idx, F_ERR) == 0)
            check_value($sformatf("access %0d load data", idx), field(idx, F_RDATA),
                        lsu_rdata_1);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h3a618616));
    lsu_en     = 1'b0;
    size       = LSU_SIZE_B;
    sign_ext   = 1'b0;
    we         = 1'b0;
    misaligned = 1'b0;
    opa        = '0;
    opb        = '0;
    wdata      = '0;
    $readmemh("tests/lsu_golden.txt", gold);
    while (n_lines < MAX_LINES && !$isunknown(gold[FIELDS*n_lines]))
      n_lines++;
    if (n_lines == 0)
      stop_run("golden file tests/lsu_golden.txt holds no accesses");
    else
    begin
      do                                  // Also covers the first cycle after release
      begin
        @(negedge clk);
        expect_idle("reset");
      end
      while (rst_n !== 1'b1);
      @(posedge clk);
      for (int i = 0; i < n_lines; i++)
        run_access(i);
      lsu_en     <= 1'b0;
      misaligned <= 1'b0;
      wait_drain();
      @(negedge clk);
      check_value("busy after drain", 0, busy);
      check_value("bus transaction count", exp_gnts, gnt_total);
      check_value("outstanding after drain", 0, outst);
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

  // Bound grows with the number of accesses, counted from reset release
  initial
  begin
    wait (rst_n === 1'b1);
    repeat (n_lines * 200) @(posedge clk);
    stop_run("watchdog expired, the run hung waiting for the DUT");
  end

endmodule

// ==== tests/tb_clk_gen.sv ====
// Testbench clock and reset
// 40 ns clock, active-low reset held for 16 cycles

`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD = 20;        // ns
  localparam int RST_CYCLES  = 16;

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;                      // Release on a rising edge
  end

endmodule
